// File: Makefile
# Verilator build and run for the SHA-256 core testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module tb_sha256_core \
		-Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/sha256_core_asserts.sv
// Protocol assertions for the SHA-256 core.
// Bound to every sha256_core instance; failures raise $error and bump err_count.
`timescale 1ns/1ps
`default_nettype none

module sha256_core_asserts (
	input wire logic                  tb_clk,
	input wire logic                  rst_n,
	input wire logic                  init,
	input wire logic                  load,
	input wire sha_types_pkg::state_t out_hash
);

	// Read by the testbench to end the run
	int unsigned err_count = 0;

	// Sequencer never starts a block and loads in the same cycle
	init_load_excl: assert property (
		@(posedge tb_clk) disable iff (!rst_n)
		!(init && load)
	)
	else
	begin
		err_count++;
		$error("init and load high in the same cycle");
	end

	// Digest only moves on the edge that saw load
	hash_only_on_load: assert property (
		@(posedge tb_clk) disable iff (!rst_n)
		!$stable(out_hash) |-> $past(load)
	)
	else
	begin
		err_count++;
		$error("out_hash changed without a load");
	end

	// Async reset clears the digest
	hash_zero_in_reset: assert property (
		@(posedge tb_clk)
		!rst_n |-> (out_hash == '0)
	)
	else
	begin
		err_count++;
		$error("out_hash not zero during reset");
	end

endmodule

bind sha256_core sha256_core_asserts u_asserts (
	.tb_clk   (tb_clk),
	.rst_n    (rst_n),
	.init     (init),
	.load     (load),
	.out_hash (out_hash)
);

`default_nettype wire

// File: dv/tb_sha256_core.sv
// Testbench for the SHA-256 compression engine.
// Hashes the FIPS "abc" and two-block vectors, with and without halt cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_sha256_core;

	import sha_const_pkg::*;
	import sha_types_pkg::*;

	localparam int clk_period   = 10;
	localparam int reset_cycles = 5;
	localparam int num_blocks   = 5;
	// init, 64 rounds, load and the check cycle
	localparam int block_cycles = rounds + 4;
	localparam int max_halts    = 16;
	localparam int budget_cycles =
		2 * (reset_cycles + 4 + num_blocks * (block_cycles + max_halts));

	// Padded message blocks, word 0 first
	localparam logic [0:15][31:0] abc_words = {32'h61626380, {14{32'h0}}, 32'h00000018};
	localparam logic [0:15][31:0] two_a_words = {
		32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
		32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
		32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
		32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000
	};
	// Padding only, message length 448 bits
	localparam logic [0:15][31:0] two_b_words = {{15{32'h0}}, 32'h000001c0};

	localparam logic [255:0] abc_digest = {
		32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
		32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
	};
	localparam logic [255:0] two_digest = {
		32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
		32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1
	};

	logic                   tb_clk;
	logic                   rst_n;
	logic                   init;
	logic                   clear;
	logic                   halt;
	logic                   load;
	logic [round_idx_w-1:0] count;
	block_t                 data;
	state_t                 out_hash;
	logic [31:0]            lcg_state;

	sha256_core UUT (
		.tb_clk   (tb_clk),
		.rst_n    (rst_n),
		.init     (init),
		.clear    (clear),
		.halt     (halt),
		.count    (count),
		.data     (data),
		.load     (load),
		.out_hash (out_hash)
	);

	always #(clk_period / 2) tb_clk = ~tb_clk;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic block_t to_block(input logic [0:15][31:0] words);
		block_t b;
		for (int i = 0; i < block_words; i++)
		begin
			b.w[i] = words[i];
		end
		return b;
	endfunction

	task automatic check_hash(input logic [255:0] expected, input string what);
		assert (out_hash == expected)
		else
		begin
			$display("MISMATCH out_hash (%s): got %h expected %h", what, out_hash, expected);
			$display("Simulation FAILED");
			$fatal(1, "digest check failed");
		end
	endtask

	// init pulse, 64 executed rounds with optional stalls, then load
	task automatic run_block(
		input logic             clr,
		input logic [0:15][31:0] words,
		input logic             use_halts
	);
		int r;
		int halts;
		r = 0;
		halts = 0;
		@(negedge tb_clk);
		init = 1'b1;
		clear = clr;
		data = to_block(words);
		halt = 1'b0;
		@(negedge tb_clk);
		init = 1'b0;
		while (r < rounds)
		begin
			// Upper LCG bits, the low ones repeat every four draws
			if (use_halts && halts < max_halts &&
				((next_random() >> 16) % 32'd4) == 32'd0)
			begin
				halt = 1'b1;
				halts++;
			end
			else
			begin
				halt = 1'b0;
				count = r[round_idx_w-1:0];
				r++;
			end
			@(negedge tb_clk);
		end
		// Rounds frozen while the digest takes the sum
		halt = 1'b1;
		load = 1'b1;
		@(negedge tb_clk);
		load = 1'b0;
	endtask

	// Bound assertion failures end the run right away
	initial
	begin
		wait (UUT.u_asserts.err_count != 0);
		$display("Protocol assertion failed in sha256_core_asserts");
		$display("Simulation FAILED");
		$fatal(1, "assertion failure");
	end

	initial
	begin
		#(budget_cycles * clk_period);
		$display("Timeout: the run did not finish within %0d cycles", budget_cycles);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		tb_clk = 1'b0;
		rst_n = 1'b0;
		init = 1'b0;
		clear = 1'b0;
		halt = 1'b1;
		load = 1'b0;
		count = '0;
		data = '0;
		lcg_state = 32'h659a;

		repeat (reset_cycles)
		begin
			@(negedge tb_clk);
			check_hash('0, "during reset");
		end
		rst_n = 1'b1;
		repeat (2)
		begin
			@(negedge tb_clk);
			check_hash('0, "after reset");
		end

		run_block(1'b1, abc_words, 1'b0);
		check_hash(abc_digest, "abc");

		run_block(1'b1, two_a_words, 1'b0);
		run_block(1'b0, two_b_words, 1'b0);
		check_hash(two_digest, "two-block");

		// Fresh message must drop the chained digest
		run_block(1'b1, abc_words, 1'b0);
		check_hash(abc_digest, "restart");

		run_block(1'b1, abc_words, 1'b1);
		check_hash(abc_digest, "abc with halts");

		@(negedge tb_clk);
		if (UUT.u_asserts.err_count == 0)
		begin
			$display("Simulation PASSED");
			$finish;
		end
		else
		begin
			$display("Simulation FAILED");
			$fatal(1, "assertion failures counted");
		end
	end

endmodule

`default_nettype wire

// File: filelist.f
hw/sha_const_pkg.sv
hw/sha_types_pkg.sv
hw/sha_schedule.sv
hw/sha_round.sv
hw/sha_digest.sv
hw/sha256_core.sv
dv/sha256_core_asserts.sv
dv/tb_sha256_core.sv

// File: hw/sha256_core.sv
// SHA-256 compression engine, top level.
// An external sequencer drives init, halt, clear, load and the round index.
`timescale 1ns/1ps
`default_nettype none

module sha256_core (
	input  wire logic                                 tb_clk,
	input  wire logic                                 rst_n,
	input  wire logic                                 init,
	input  wire logic                                 clear,
	input  wire logic                                 halt,
	input  wire logic [sha_const_pkg::round_idx_w-1:0] count,
	input  wire sha_types_pkg::block_t                data,
	input  wire logic                                 load,
	output sha_types_pkg::state_t                     out_hash
);

	import sha_const_pkg::*;
	import sha_types_pkg::*;

	state_t            chain;
	state_t            work;
	logic [word_w-1:0] w_cur;

	// Decode stage
	sha_schedule u_schedule (
		.tb_clk (tb_clk),
		.rst_n  (rst_n),
		.init   (init),
		.halt   (halt),
		.data   (data),
		.w_cur  (w_cur)
	);

	// Execute stage
	sha_round u_round (
		.tb_clk (tb_clk),
		.rst_n  (rst_n),
		.init   (init),
		.halt   (halt),
		.count  (count),
		.chain  (chain),
		.w_cur  (w_cur),
		.work   (work)
	);

	// Result stage
	sha_digest u_digest (
		.tb_clk   (tb_clk),
		.rst_n    (rst_n),
		.init     (init),
		.clear    (clear),
		.load     (load),
		.work     (work),
		.chain    (chain),
		.out_hash (out_hash)
	);

endmodule

`default_nettype wire

// File: hw/sha_const_pkg.sv
// SHA-256 constants shared by the core stages.
// Round constants, the initial hash value, word sizes and a rotate helper.
`default_nettype none

package sha_const_pkg;

	localparam int word_w      = 32;
	localparam int rounds      = 64;
	localparam int round_idx_w = 7;
	localparam int block_words = 16;

	// Bits of count needed to select a round constant
	localparam int k_idx_w = $clog2(rounds);

	// Entry 0 sits at the MSB end, so k_table[n] is the constant of round n
	localparam logic [0:rounds-1][word_w-1:0] k_table = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// H0 to H7 from FIPS 180-4
	// Same bit layout as state_t, H0 lands on field a
	localparam logic [0:7][word_w-1:0] h_init = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	// Rotate right by n bits, n below word_w
	function automatic logic [word_w-1:0] rotr(
		input logic [word_w-1:0] x,
		input int unsigned       n
	);
		return (x >> n) | (x << (word_w - n));
	endfunction

endpackage

`default_nettype wire

// File: hw/sha_digest.sv
// Chaining digest of the SHA-256 core.
// Picks the chaining value, keeps it as base and adds the working state on load.
`timescale 1ns/1ps
`default_nettype none

module sha_digest (
	input  wire logic                  tb_clk,
	input  wire logic                  rst_n,
	input  wire logic                  init,
	input  wire logic                  clear,
	input  wire logic                  load,
	input  wire sha_types_pkg::state_t work,
	output sha_types_pkg::state_t      chain,
	output sha_types_pkg::state_t      out_hash
);

	import sha_const_pkg::*;
	import sha_types_pkg::*;

	state_t base;
	state_t digest;
	state_t sum;

	// New message starts from H0..H7, otherwise continue from the last digest
	assign chain = clear ? state_t'(h_init) : digest;

	// Word-wise add, each modulo 2^32
	always_comb
	begin
		sum.a = base.a + work.a;
		sum.b = base.b + work.b;
		sum.c = base.c + work.c;
		sum.d = base.d + work.d;
		sum.e = base.e + work.e;
		sum.f = base.f + work.f;
		sum.g = base.g + work.g;
		sum.h = base.h + work.h;
	end

	always_ff @(posedge tb_clk)
	begin
		if (init)
		begin
			base <= chain;
		end
	end

	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			digest <= '0;
		end
		else if (load)
		begin
			digest <= sum;
		end
	end

	assign out_hash = digest;

endmodule

`default_nettype wire

// File: hw/sha_round.sv
// Compression round of the SHA-256 core.
// Loads the working state on init and applies one round per running cycle.
`timescale 1ns/1ps
`default_nettype none

module sha_round (
	input  wire logic                                 tb_clk,
	input  wire logic                                 rst_n,
	input  wire logic                                 init,
	input  wire logic                                 halt,
	input  wire logic [sha_const_pkg::round_idx_w-1:0] count,
	input  wire sha_types_pkg::state_t                chain,
	input  wire logic [sha_const_pkg::word_w-1:0]     w_cur,
	output sha_types_pkg::state_t                     work
);

	import sha_const_pkg::*;
	import sha_types_pkg::*;

	state_t            nxt;
	logic [word_w-1:0] k_cur;
	logic [word_w-1:0] t1;
	logic [word_w-1:0] t2;

	function automatic logic [word_w-1:0] big_sigma0(input logic [word_w-1:0] x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic logic [word_w-1:0] big_sigma1(input logic [word_w-1:0] x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic logic [word_w-1:0] ch(
		input logic [word_w-1:0] x,
		input logic [word_w-1:0] y,
		input logic [word_w-1:0] z
	);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic logic [word_w-1:0] maj(
		input logic [word_w-1:0] x,
		input logic [word_w-1:0] y,
		input logic [word_w-1:0] z
	);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

	// Sequencer keeps count within 0..63, top bit is always zero
	assign k_cur = k_table[count[k_idx_w-1:0]];

	always_comb
	begin
		t1 = work.h + big_sigma1(work.e) + ch(work.e, work.f, work.g) + k_cur + w_cur;
		t2 = big_sigma0(work.a) + maj(work.a, work.b, work.c);

		nxt.a = t1 + t2;
		nxt.b = work.a;
		nxt.c = work.b;
		nxt.d = work.c;
		nxt.e = work.d + t1;
		nxt.f = work.e;
		nxt.g = work.f;
		nxt.h = work.g;
	end

	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			work <= '0;
		end
		else if (init)
		begin
			work <= chain;
		end
		else if (!halt)
		begin
			work <= nxt;
		end
	end

endmodule

`default_nettype wire

// File: hw/sha_schedule.sv
// Message schedule of the SHA-256 core.
// Holds a 16-word window loaded on init and produces W for each round.
`timescale 1ns/1ps
`default_nettype none

module sha_schedule (
	input  wire logic                          tb_clk,
	input  wire logic                          rst_n,
	input  wire logic                          init,
	input  wire logic                          halt,
	input  wire sha_types_pkg::block_t         data,
	output logic [sha_const_pkg::word_w-1:0]   w_cur
);

	import sha_const_pkg::*;

	// window[0] holds W for the round executing this cycle
	logic [block_words-1:0][word_w-1:0] window;
	logic [word_w-1:0]                  w_next;

	function automatic logic [word_w-1:0] small_sigma0(input logic [word_w-1:0] x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic logic [word_w-1:0] small_sigma1(input logic [word_w-1:0] x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	// W[t+16] from W[t], W[t+1], W[t+9] and W[t+14]
	always_comb
	begin
		w_next = small_sigma1(window[14]) + window[9] + small_sigma0(window[1]) + window[0];
	end

	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			window <= '0;
		end
		else if (init)
		begin
			window <= data.w;
		end
		else if (!halt)
		begin
			// Slide down one word and append the expanded one
			for (int i = 0; i < block_words - 1; i++)
			begin
				window[i] <= window[i + 1];
			end
			window[block_words - 1] <= w_next;
		end
	end

	assign w_cur = window[0];

endmodule

`default_nettype wire

// File: hw/sha_types_pkg.sv
// Packed struct types carried between the SHA-256 stages.
// Compile after sha_const_pkg, which gives the word width.
`default_nettype none

package sha_types_pkg;

	import sha_const_pkg::*;

	typedef logic [word_w-1:0] word_t;

	// One 512-bit message block
	// w[0] is the first big-endian word of the block
	typedef struct packed {
		logic [block_words-1:0][word_w-1:0] w;
	} block_t;

	// Eight working variables, also used for chaining value and digest
	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
		word_t f;
		word_t g;
		word_t h;
	} state_t;

endpackage

`default_nettype wire
